// ==== bench/etx_model.svh ====
`ifndef ETX_MODEL_SVH
`define ETX_MODEL_SVH

`default_nettype none

// ##########################################################
// Reference rules of the transmit stage
// ##########################################################

// Header word, access in bit 0
function automatic etx_pkg::lane_t expected_header
(
  input logic               access,
  input logic               write,
  input etx_pkg::datamode_t datamode,
  input etx_pkg::ctrlmode_t ctrlmode,
  input etx_pkg::addr_t     dstaddr
);
  etx_pkg::lane_t h;
  h        = '0;
  h[0]     = access;
  h[1]     = write;
  h[3:2]   = datamode;
  h[7:4]   = dstaddr[3:0];
  h[31:8]  = dstaddr[27:4];
  h[35:32] = dstaddr[31:28];
  h[39:36] = ctrlmode;
  h[47]    = ~write;          // Read flag
  return h;
endfunction

// Test register reload, write after read and read after write
function automatic etx_pkg::packet_t next_test_packet
(
  input etx_pkg::packet_t cur,
  input etx_pkg::chipid_t chip,
  input etx_pkg::chipid_t id
);
  etx_pkg::packet_t p;
  p       = '0;
  p[39:8] = {chip, 20'd0};    // Destination chip, offset zero
  if (!cur[1])
  begin
    p[3:0]    = 4'b1011;      // Word write
    p[71:40]  = 32'h5555_5555;
    p[103:72] = 32'h5555_5555;
  end
  else
  begin
    p[3:0]    = 4'b1001;      // Word read
    p[71:40]  = 32'hAAAA_AAAA;
    p[103:72] = {id, 20'hD0000}; // Readback register
  end
  return p;
endfunction

// Acceptance in the current cycle
function automatic logic frame_accepted
(
  input logic             busy,
  input logic             testmode,
  input logic             enable,
  input logic             access,
  input logic             write,
  input etx_pkg::addr_t   dstaddr,
  input logic             rd_sync,
  input logic             wr_sync,
  input etx_pkg::chipid_t id
);
  logic blocked;
  blocked = write ? wr_sync : rd_sync;
  if (busy)
  begin
    return 1'b0;              // Header cycle in flight
  end
  return testmode || (enable && access && (dstaddr[31:20] != id) && !blocked);
endfunction

// Data lane for a given frame code
function automatic etx_pkg::lane_t expected_lane
(
  input etx_pkg::frame_t frame,
  input logic [127:0]    word
);
  if (frame == 8'h3F)
  begin
    return word[63:0];
  end
  else if (frame == 8'hFF)
  begin
    return word[127:64];
  end
  return '0;
endfunction

`default_nettype wire

`endif

// ==== bench/etx_protocol_tb.sv ====
`timescale 1ns/1ps
`include "etx_model.svh"
`default_nettype none

module etx_protocol_tb;

  localparam etx_pkg::chipid_t DUT_ID = 12'h810;
  localparam int SYNC_STAGES   = 2;
  localparam int SEED          = 16676;
  localparam int RESET_CYCLES  = 3;
  localparam int IDLE_CYCLES   = 4;
  localparam int RANDOM_CYCLES = 400;
  localparam int SELF_CYCLES   = 101;   // One extra to flush
  localparam int STALL_SETUP   = 12;    // Quiet cycles plus edge search
  localparam int BP_CYCLES     = 100;
  localparam int TEST_CYCLES   = 61;    // Odd, so the second burst starts on the write
  localparam int TEST_BURSTS   = 2;
  localparam int DRAIN_CYCLES  = 4;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES +
                                 (SELF_CYCLES + 1) + 2 * (STALL_SETUP + BP_CYCLES + 1) +
                                 TEST_BURSTS * (TEST_CYCLES + DRAIN_CYCLES);
  localparam int WATCHDOG_NS   = TOTAL_CYCLES * 20 + 2000;

  logic clk;
  logic reset;
  logic testmode;
  logic etx_access;
  logic tx_enable;
  logic tx_rd_wait;
  logic tx_wr_wait;
  logic etx_rd_wait;
  logic etx_wr_wait;
  etx_pkg::packet_t etx_packet;
  etx_pkg::chipid_t chipid;
  etx_pkg::frame_t  tx_frame_par;
  etx_pkg::lane_t   tx_data_par;

  // Model state
  logic [SYNC_STAGES-1:0] m_rd_chain;
  logic [SYNC_STAGES-1:0] m_wr_chain;
  etx_pkg::packet_t       m_test;
  etx_pkg::packet_t       m_pkt;    // Packet seen by the framer
  logic                   m_access;
  logic                   m_busy;   // Header cycle showing
  etx_pkg::frame_t        m_frame;
  logic [127:0]           m_word;

  // Bookkeeping
  string           cur_test;
  int              errors;
  int              errors_at_start;
  int              tests_run;
  int              tests_failed;
  int              checks;
  int              starts;
  int              write_starts;
  int              read_starts;
  etx_pkg::frame_t last_frame;
  int unsigned     seed_ret;

  etx_protocol #(.ID(DUT_ID), .SYNC_STAGES(SYNC_STAGES)) dut
  (
    .clk          (clk),
    .reset        (reset),
    .testmode     (testmode),
    .etx_access   (etx_access),
    .etx_packet   (etx_packet),
    .tx_enable    (tx_enable),
    .chipid       (chipid),
    .tx_rd_wait   (tx_rd_wait),
    .tx_wr_wait   (tx_wr_wait),
    .etx_rd_wait  (etx_rd_wait),
    .etx_wr_wait  (etx_wr_wait),
    .tx_frame_par (tx_frame_par),
    .tx_data_par  (tx_data_par)
  );

  always #10 clk = ~clk;   // 20 ns period

  // ##########################################################
  // Cycle model stepped on the rising edge
  // ##########################################################
  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      m_rd_chain = '0;
      m_wr_chain = '0;
      m_test     = '0;
      m_busy     = 1'b0;
      m_frame    = '0;
      m_word     = '0;
    end
    else
    begin
      m_pkt    = testmode ? m_test : etx_packet;
      m_access = testmode | etx_access;
      if (frame_accepted(m_busy, testmode, tx_enable, m_access, m_pkt[1], m_pkt[39:8],
                         m_rd_chain[SYNC_STAGES-1], m_wr_chain[SYNC_STAGES-1], DUT_ID))
      begin
        m_word  = {m_pkt[71:40], m_pkt[103:72],
                   expected_header(m_access, m_pkt[1], m_pkt[3:2], m_pkt[7:4], m_pkt[39:8])};
        m_frame = 8'h3F;
        m_busy  = 1'b1;
      end
      else if (m_busy)
      begin
        m_frame = 8'hFF;   // Body follows header
        m_busy  = 1'b0;
      end
      else
      begin
        m_frame = '0;
      end
      if (testmode)
      begin
        m_test = next_test_packet(m_test, chipid, DUT_ID);
      end
      m_rd_chain = {m_rd_chain[SYNC_STAGES-2:0], tx_rd_wait};
      m_wr_chain = {m_wr_chain[SYNC_STAGES-2:0], tx_wr_wait};
    end
  end

  // ##########################################################
  // Helpers
  // ##########################################################
  task automatic report_fail(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  // Compare lanes and stalls and count frame starts
  task automatic check_outputs;
    etx_pkg::lane_t exp_lane;
    logic           exp_rd;
    logic           exp_wr;
    exp_lane = expected_lane(m_frame, m_word);
    exp_rd   = m_rd_chain[SYNC_STAGES-1] | m_busy;
    exp_wr   = m_wr_chain[SYNC_STAGES-1] | m_busy;
    checks++;
    assert (tx_frame_par == m_frame) else
    begin
      $display("CHECK FAILED %s tx_frame_par expected %h actual %h",
               cur_test, m_frame, tx_frame_par);
      errors++;
    end
    assert (tx_data_par == exp_lane) else
    begin
      $display("CHECK FAILED %s tx_data_par expected %h actual %h",
               cur_test, exp_lane, tx_data_par);
      errors++;
    end
    assert (etx_rd_wait == exp_rd) else
    begin
      $display("CHECK FAILED %s etx_rd_wait expected %b actual %b",
               cur_test, exp_rd, etx_rd_wait);
      errors++;
    end
    assert (etx_wr_wait == exp_wr) else
    begin
      $display("CHECK FAILED %s etx_wr_wait expected %b actual %b",
               cur_test, exp_wr, etx_wr_wait);
      errors++;
    end
    assert (!(tx_frame_par == 8'h3F && last_frame == 8'h3F)) else
      report_fail("two frames started in adjacent cycles");
    if (tx_frame_par == 8'h3F)
    begin
      starts++;
      if (tx_data_par[1])   // Write bit of the header
        write_starts++;
      else
        read_starts++;
    end
    last_frame = tx_frame_par;
  endtask

  task automatic next_cycle;
    @(negedge clk);   // Outputs settled and safe to drive
    check_outputs();
  endtask

  task automatic drive_inputs(input logic acc, input logic en, input logic rdw,
                              input logic wrw, input etx_pkg::packet_t pkt);
    etx_access = acc;
    tx_enable  = en;
    tx_rd_wait = rdw;
    tx_wr_wait = wrw;
    etx_packet = pkt;
  endtask

  function automatic logic rand_bit(input int pct);
    return $urandom_range(99, 0) < pct;
  endfunction

  // Random chip ID other than our own
  function automatic etx_pkg::chipid_t other_chip;
    logic [31:0] r;
    r = $urandom();
    if (r[11:0] == DUT_ID)
      r[0] = ~r[0];
    return r[11:0];
  endfunction

  function automatic etx_pkg::packet_t make_packet(input logic wr, input etx_pkg::chipid_t chip);
    logic [31:0] r;
    r = $urandom();
    return {$urandom(), $urandom(), chip, r[19:0], r[25:20], wr, r[31]};
  endfunction

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
    starts          = 0;
    write_starts    = 0;
    read_starts     = 0;
  endtask

  task automatic end_test;
    tests_run++;
    if (errors == errors_at_start)
      $display("test %s done, no errors", cur_test);
    else
    begin
      tests_failed++;
      $display("test %s done, %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  // Raise one wait with quiet traffic and count cycles to the stall
  task automatic check_stall_delay(input logic wr_side);
    int n;
    drive_inputs(1'b0, 1'b0, 1'b0, 1'b0, '0);
    repeat (4) next_cycle();
    if (wr_side)
      tx_wr_wait = 1'b1;
    else
      tx_rd_wait = 1'b1;
    n = 0;
    do
    begin
      next_cycle();
      n++;
    end while (n < 8 && !(wr_side ? etx_wr_wait : etx_rd_wait));
    assert (n == SYNC_STAGES) else
    begin
      $display("CHECK FAILED %s stall delay expected %0d actual %0d",
               cur_test, SYNC_STAGES, n);
      errors++;
    end
  endtask

  task automatic run_backpressure(input logic wr_side);
    int blocked;
    int passed;
    check_stall_delay(wr_side);
    for (int i = 0; i < BP_CYCLES; i++)
    begin
      next_cycle();
      assert (wr_side ? etx_wr_wait : etx_rd_wait) else
        report_fail("stall output dropped while its wait input was held high");
      drive_inputs(1'b1, 1'b1, !wr_side, wr_side, make_packet(rand_bit(50), other_chip()));
    end
    next_cycle();
    blocked = wr_side ? write_starts : read_starts;
    passed  = wr_side ? read_starts : write_starts;
    assert (blocked == 0) else report_fail("blocked transactions were framed");
    assert (passed > 0) else report_fail("no transactions of the other kind were framed");
  endtask

  // ##########################################################
  // Test sequence
  // ##########################################################
  initial
  begin
    logic [31:0] r;
    seed_ret     = $urandom(SEED);
    clk          = 1'b0;
    reset        = 1'b1;
    testmode     = 1'b0;
    chipid       = '0;
    drive_inputs(1'b0, 1'b0, 1'b0, 1'b0, '0);
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    checks       = 0;
    last_frame   = '0;

    begin_test("reset");
    for (int i = 0; i < RESET_CYCLES + IDLE_CYCLES; i++)
    begin
      next_cycle();
      assert (tx_frame_par == '0 && tx_data_par == '0 && !etx_rd_wait && !etx_wr_wait) else
        report_fail("outputs not quiet during or after reset");
      if (i == RESET_CYCLES - 1)
        reset = 1'b0;   // Released on a falling edge
    end
    end_test();

    begin_test("random_traffic");
    for (int i = 0; i < RANDOM_CYCLES; i++)
    begin
      next_cycle();
      r = $urandom();
      drive_inputs(rand_bit(70), rand_bit(85), rand_bit(25), rand_bit(25),
                   make_packet(rand_bit(50), r[11:0]));
    end
    assert (starts > 0) else report_fail("no frame was sent");
    end_test();

    begin_test("self_drop");
    for (int i = 0; i < SELF_CYCLES; i++)
    begin
      next_cycle();
      if (i == 0)
        starts = 0;     // Ignore a frame left from the last test
      drive_inputs(1'b1, 1'b1, rand_bit(20), rand_bit(20), make_packet(rand_bit(50), DUT_ID));
    end
    next_cycle();
    assert (starts == 0) else report_fail("a packet to the own ID was framed");
    end_test();

    begin_test("wr_backpressure");
    run_backpressure(1'b1);
    end_test();

    begin_test("rd_backpressure");
    run_backpressure(1'b0);
    end_test();

    begin_test("testmode");
    for (int b = 0; b < TEST_BURSTS; b++)
    begin
      // Each burst frames the packet held in the test register on entry
      drive_inputs(1'b0, 1'b0, 1'b0, 1'b0, '0);
      r        = $urandom();
      chipid   = r[11:0];
      testmode = 1'b1;
      for (int i = 0; i < TEST_CYCLES; i++)
      begin
        next_cycle();
        drive_inputs(rand_bit(50), rand_bit(50), rand_bit(30), rand_bit(30),
                     make_packet(rand_bit(50), r[23:12]));
      end
      testmode = 1'b0;
      drive_inputs(1'b0, 1'b0, 1'b0, 1'b0, '0);
      repeat (DRAIN_CYCLES) next_cycle();
    end
    assert (starts > TEST_CYCLES / 4) else report_fail("test mode produced too few frames");
    assert (write_starts > 0 && read_starts > 0) else
      report_fail("test mode did not frame both the test write and the test read");
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the test lengths
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/etx_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module etx_framer
#(
  parameter etx_pkg::chipid_t ID = '0
)
(
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 testmode,
  input  wire logic                 tx_enable,
  input  wire logic                 access,
  input  wire logic                 write,
  input  wire etx_pkg::datamode_t   datamode,
  input  wire etx_pkg::ctrlmode_t   ctrlmode,
  input  wire etx_pkg::addr_t       dstaddr,
  input  wire etx_pkg::data_t       data,
  input  wire etx_pkg::addr_t       srcaddr,
  input  wire logic                 rd_wait_sync,
  input  wire logic                 wr_wait_sync,
  output etx_pkg::frame_t           tx_frame_par,
  output etx_pkg::lane_t            tx_data_par,
  output logic                      etx_rd_wait,
  output logic                      etx_wr_wait
);

  etx_pkg::tx_state_t state_q;
  etx_pkg::frame_t    frame_q;
  etx_pkg::lane_t     header;
  logic [127:0]       word_q;   // {data, srcaddr, header}
  logic               self_addr;
  logic               io_wait;  // Matching synced wait
  logic               accept;

  // ##########################################################
  // Acceptance
  // ##########################################################
  // Packets to our own chip ID never leave
  assign self_addr = (dstaddr[etx_pkg::AW-1 -: 12] == ID);

  // Writes and reads blocked separately
  assign io_wait = write ? wr_wait_sync : rd_wait_sync;

  // Test mode sends regardless of enable and waits
  assign accept = (state_q == etx_pkg::TX_IDLE) &&
                  (testmode ||
                   (tx_enable && access && !self_addr && !io_wait));

  // Header word, byte 0 first on the lane
  assign header = {16'd0,                        // Unused bytes
                   ~write, 7'd0,                 // Read flag byte
                   ctrlmode, dstaddr[31:28],
                   dstaddr[27:4],
                   dstaddr[3:0], datamode, write, access};

  // ##########################################################
  // Frame state machine
  // ##########################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q <= etx_pkg::TX_IDLE;
      frame_q <= '0;
    end
    else
    begin
      if (accept)
      begin
        state_q <= etx_pkg::TX_BODY;     // Hold off one cycle
        frame_q <= etx_pkg::FRAME_START;
      end
      else if (state_q == etx_pkg::TX_BODY)
      begin
        state_q <= etx_pkg::TX_IDLE;     // New accept allowed here
        frame_q <= etx_pkg::FRAME_BODY;
      end
      else
      begin
        frame_q <= '0;                   // Idle lane
      end
    end
  end

  // Frame word captured at acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      word_q <= {data, srcaddr, header};
    end
  end

  // ##########################################################
  // Lane outputs
  // ##########################################################
  assign tx_frame_par = frame_q;

  always_comb
  begin
    case (frame_q)
      etx_pkg::FRAME_START: tx_data_par = word_q[63:0];
      etx_pkg::FRAME_BODY:  tx_data_par = word_q[127:64];
      default:              tx_data_par = '0;   // Quiet between frames
    endcase
  end

  // Stall system side while IO waits or during the header cycle
  assign etx_wr_wait = wr_wait_sync | (state_q == etx_pkg::TX_BODY);
  assign etx_rd_wait = rd_wait_sync | (state_q == etx_pkg::TX_BODY);

endmodule

`default_nettype wire

// ==== design/etx_pkg.sv ====
`default_nettype none

package etx_pkg;

  // ##########################################################
  // Widths fixed by the mesh packet format
  // ##########################################################
  localparam int PW = 104;
  localparam int AW = 32;
  localparam int DW = 32;

  typedef logic [PW-1:0] packet_t;   // Full mesh packet
  typedef logic [AW-1:0] addr_t;
  typedef logic [DW-1:0] data_t;
  typedef logic [1:0]    datamode_t; // Transfer size
  typedef logic [3:0]    ctrlmode_t;
  typedef logic [11:0]   chipid_t;   // Top bits of an address
  typedef logic [7:0]    frame_t;    // Frame lane
  typedef logic [63:0]   lane_t;     // Data lane

  // ##########################################################
  // Frame lane codes
  // ##########################################################
  localparam frame_t FRAME_START = 8'h3F; // Header cycle
  localparam frame_t FRAME_BODY  = 8'hFF; // Data and source cycle

  // ##########################################################
  // Test pattern
  // ##########################################################
  localparam data_t       TEST_WRITE_DATA      = 32'h5555_5555;
  localparam data_t       TEST_READ_DATA       = 32'hAAAA_AAAA; // Dummy
  localparam logic [19:0] TEST_READBACK_OFFSET = 20'hD0000;
  localparam datamode_t   TEST_DATAMODE        = 2'd2;          // Word

  // Low nibble of the test packets: datamode, write, access
  localparam logic [3:0] TEST_WRITE_CODE = {TEST_DATAMODE, 1'b1, 1'b1};
  localparam logic [3:0] TEST_READ_CODE  = {TEST_DATAMODE, 1'b0, 1'b1};

  // Framer state, body flag set in the FRAME_START cycle
  typedef enum logic
  {
    TX_IDLE,
    TX_BODY
  } tx_state_t;

endpackage

`default_nettype wire

// ==== design/etx_protocol.sv ====
`timescale 1ns/1ps
`default_nettype none

module etx_protocol
#(
  parameter etx_pkg::chipid_t ID          = '0,
  parameter int               SYNC_STAGES = 2
)
(
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                testmode,    // Replaces system traffic
  input  wire logic                etx_access,
  input  wire etx_pkg::packet_t    etx_packet,
  input  wire logic                tx_enable,
  input  wire etx_pkg::chipid_t    chipid,
  input  wire logic                tx_rd_wait,  // Async from IO
  input  wire logic                tx_wr_wait,  // Async from IO
  output logic                     etx_rd_wait, // Stall to system side
  output logic                     etx_wr_wait,
  output etx_pkg::frame_t          tx_frame_par,
  output etx_pkg::lane_t           tx_data_par
);

  // Decoded packet fields
  logic               access;
  logic               write;
  etx_pkg::datamode_t datamode;
  etx_pkg::ctrlmode_t ctrlmode;
  etx_pkg::addr_t     dstaddr;
  etx_pkg::data_t     data;
  etx_pkg::addr_t     srcaddr;

  // Waits in the clk domain
  logic rd_wait_sync;
  logic wr_wait_sync;

  // ##########################################################
  // Packet source and IO wait synchronizer
  // ##########################################################
  etx_source #(.ID(ID)) u_source
  (
    .clk        (clk),
    .reset      (reset),
    .testmode   (testmode),
    .etx_access (etx_access),
    .etx_packet (etx_packet),
    .chipid     (chipid),
    .access     (access),
    .write      (write),
    .datamode   (datamode),
    .ctrlmode   (ctrlmode),
    .dstaddr    (dstaddr),
    .data       (data),
    .srcaddr    (srcaddr)
  );

  etx_wait_sync #(.SYNC_STAGES(SYNC_STAGES)) u_wait_sync
  (
    .clk          (clk),
    .reset        (reset),
    .tx_rd_wait   (tx_rd_wait),
    .tx_wr_wait   (tx_wr_wait),
    .rd_wait_sync (rd_wait_sync),
    .wr_wait_sync (wr_wait_sync)
  );

  // ##########################################################
  // Framer, drives the IO lanes and stalls
  // ##########################################################
  etx_framer #(.ID(ID)) u_framer
  (
    .clk          (clk),
    .reset        (reset),
    .testmode     (testmode),
    .tx_enable    (tx_enable),
    .access       (access),
    .write        (write),
    .datamode     (datamode),
    .ctrlmode     (ctrlmode),
    .dstaddr      (dstaddr),
    .data         (data),
    .srcaddr      (srcaddr),
    .rd_wait_sync (rd_wait_sync),
    .wr_wait_sync (wr_wait_sync),
    .tx_frame_par (tx_frame_par),
    .tx_data_par  (tx_data_par),
    .etx_rd_wait  (etx_rd_wait),
    .etx_wr_wait  (etx_wr_wait)
  );

endmodule

`default_nettype wire

// ==== design/etx_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module etx_source
#(
  parameter etx_pkg::chipid_t ID = '0
)
(
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                testmode,
  input  wire logic                etx_access,
  input  wire etx_pkg::packet_t    etx_packet,
  input  wire etx_pkg::chipid_t    chipid,
  output logic                     access,
  output logic                     write,
  output etx_pkg::datamode_t       datamode,
  output etx_pkg::ctrlmode_t       ctrlmode,
  output etx_pkg::addr_t           dstaddr,
  output etx_pkg::data_t           data,
  output etx_pkg::addr_t           srcaddr
);

  etx_pkg::packet_t test_q;   // Alternating test packet
  etx_pkg::packet_t pkt_sel;  // Packet feeding the decode

  // ##########################################################
  // Test packet generator
  // ##########################################################
  // Write to the chip ID, then read back from own register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      test_q <= '0;
    end
    else if (testmode)
    begin
      if (!test_q[1]) // Last one was a read
      begin
        test_q <= {etx_pkg::TEST_WRITE_DATA,   // Source
                   etx_pkg::TEST_WRITE_DATA,   // Data
                   chipid, 20'd0,              // Destination
                   4'd0,                       // Ctrlmode
                   etx_pkg::TEST_WRITE_CODE};
      end
      else
      begin
        test_q <= {ID, etx_pkg::TEST_READBACK_OFFSET, // Readback reg
                   etx_pkg::TEST_READ_DATA,           // Dummy data
                   chipid, 20'd0,                     // Read address
                   4'd0,
                   etx_pkg::TEST_READ_CODE};
      end
    end
  end

  // Test traffic replaces system traffic
  assign pkt_sel = testmode ? test_q : etx_packet;

  // Access always on in test mode
  assign access = testmode | etx_access;

  // ##########################################################
  // Field decode
  // ##########################################################
  assign write    = pkt_sel[1];
  assign datamode = pkt_sel[3:2];
  assign ctrlmode = pkt_sel[7:4];
  assign dstaddr  = pkt_sel[39:8];    // Top 12 bits pick the chip
  assign data     = pkt_sel[71:40];
  assign srcaddr  = pkt_sel[103:72];  // Return address for reads

endmodule

`default_nettype wire

// ==== design/etx_wait_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module etx_wait_sync
#(
  parameter int SYNC_STAGES = 2  // At least 2
)
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic tx_rd_wait,    // Async from IO
  input  wire logic tx_wr_wait,    // Async from IO
  output logic      rd_wait_sync,
  output logic      wr_wait_sync
);

  logic [SYNC_STAGES-1:0] rd_chain;
  logic [SYNC_STAGES-1:0] wr_chain;

  // One shift chain per wait, input enters at bit 0
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rd_chain <= '0;
      wr_chain <= '0;
    end
    else
    begin
      rd_chain <= {rd_chain[SYNC_STAGES-2:0], tx_rd_wait};
      wr_chain <= {wr_chain[SYNC_STAGES-2:0], tx_wr_wait};
    end
  end

  // Last stage, SYNC_STAGES edges after the input
  assign rd_wait_sync = rd_chain[SYNC_STAGES-1];
  assign wr_wait_sync = wr_chain[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
design/etx_pkg.sv
design/etx_source.sv
design/etx_wait_sync.sv
design/etx_framer.sv
design/etx_protocol.sv
bench/etx_protocol_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the transmit stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f list.f \
  --top-module etx_protocol_tb \
  --Mdir obj_dir \
  -o etx_sim

./obj_dir/etx_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
  exit 0
fi
echo "run.sh: simulation failed, see sim.log"
exit 1
